/* compile.f */
src/boot_pkg.sv
src/uart_rx.sv
src/program_loader.sv
src/mem_arbiter.sv
src/instr_mem.sv
src/fetch_unit.sv
src/boot_top.sv
tb/tb_clock.sv
tb/boot_top_tb.sv

/* src/boot_pkg.sv */
`default_nettype none

package boot_pkg;

  // uart bit period in clocks, kept short for simulation
  localparam int clks_per_bit = 8;
  localparam int bit_cnt_w = $clog2(clks_per_bit);

  // instruction memory geometry
  localparam int mem_words = 256;
  localparam int addr_w = 8;

  // the two words the boot path knows about
  localparam logic [31:0] nop_instr = 32'h0000_0013;
  localparam logic [31:0] halt_instr = 32'hffff_ffff;

  // nop words written from the marker address on
  localparam int pad_nops = 6;

  typedef enum logic [1:0] {
    rx_idle,
    rx_start_bit,
    rx_data_bits,
    rx_stop_bit
  } rx_state_t;

  // byte_n means n bytes of the current word are in
  typedef enum logic [2:0] {
    load_idle,
    load_byte_1,
    load_byte_2,
    load_byte_3,
    load_done,
    load_pad,
    load_finished
  } load_state_t;

  typedef enum logic [1:0] {
    fetch_wait_start,
    fetch_request,
    fetch_wait_data,
    fetch_halted
  } fetch_state_t;

endpackage

`default_nettype wire

/* src/boot_top.sv */
`timescale 1ns/1ps
`default_nettype none

module boot_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        rx_serial,
  output logic [31:0]                 instr,
  output logic [boot_pkg::addr_w-1:0] instr_addr,
  output logic                        instr_valid,
  output logic                        start,
  output logic                        halted
);

  import boot_pkg::*;

  logic [7:0] rx_byte;
  logic rx_byte_valid;

  // loader side of the arbiter
  logic wr_req;
  logic [addr_w-1:0] wr_addr;
  logic [31:0] wr_data;

  // fetch side of the arbiter
  logic rd_req;
  logic [addr_w-1:0] rd_addr;
  logic rd_gnt;
  logic rd_valid;
  logic [31:0] rd_data;

  logic mem_en;
  logic mem_we;
  logic [addr_w-1:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [31:0] mem_rdata;

  uart_rx u_uart_rx (
    .clk          (clk),
    .rst          (rst),
    .rx_serial    (rx_serial),
    .rx_byte      (rx_byte),
    .rx_byte_valid(rx_byte_valid)
  );

  program_loader u_loader (
    .clk          (clk),
    .rst          (rst),
    .rx_byte      (rx_byte),
    .rx_byte_valid(rx_byte_valid),
    .wr_req       (wr_req),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .start        (start)
  );

  mem_arbiter u_arbiter (
    .clk      (clk),
    .rst      (rst),
    .wr_req   (wr_req),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_req   (rd_req),
    .rd_addr  (rd_addr),
    .rd_gnt   (rd_gnt),
    .rd_valid (rd_valid),
    .rd_data  (rd_data),
    .mem_en   (mem_en),
    .mem_we   (mem_we),
    .mem_addr (mem_addr),
    .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata)
  );

  instr_mem #(
    .depth(mem_words),
    .aw   (addr_w)
  ) u_mem (
    .clk  (clk),
    .en   (mem_en),
    .we   (mem_we),
    .addr (mem_addr),
    .wdata(mem_wdata),
    .rdata(mem_rdata)
  );

  fetch_unit u_fetch (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .rd_req     (rd_req),
    .rd_addr    (rd_addr),
    .rd_gnt     (rd_gnt),
    .rd_valid   (rd_valid),
    .rd_data    (rd_data),
    .instr      (instr),
    .instr_addr (instr_addr),
    .instr_valid(instr_valid),
    .halted     (halted)
  );

endmodule

`default_nettype wire

/* src/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        start,
  output logic                        rd_req,
  output logic [boot_pkg::addr_w-1:0] rd_addr,
  input  logic                        rd_gnt,
  input  logic                        rd_valid,
  input  logic [31:0]                 rd_data,
  output logic [31:0]                 instr,
  output logic [boot_pkg::addr_w-1:0] instr_addr,
  output logic                        instr_valid,
  output logic                        halted
);

  import boot_pkg::*;

  fetch_state_t state;
  logic [addr_w-1:0] fetch_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= fetch_wait_start;
      fetch_addr <= '0;
    end else begin
      case (state)
        fetch_wait_start: begin
          if (start) begin
            state <= fetch_request;
          end
        end

        // hold the request until the loader lets go of the port
        fetch_request: begin
          if (rd_gnt) begin
            state <= fetch_wait_data;
          end
        end

        fetch_wait_data: begin
          if (rd_valid) begin
            if (rd_data == halt_instr) begin
              state <= fetch_halted;
            end else begin
              fetch_addr <= fetch_addr + 1'b1;
              state <= fetch_request;
            end
          end
        end

        fetch_halted: begin
          state <= fetch_halted;
        end

        default: begin
          state <= fetch_wait_start;
        end
      endcase
    end
  end

  assign rd_req = (state == fetch_request);
  assign rd_addr = fetch_addr;

  // word is presented in the cycle it returns
  assign instr = rd_data;
  assign instr_addr = fetch_addr;
  assign instr_valid = rd_valid && (state == fetch_wait_data);
  assign halted = (state == fetch_halted);

  // only one read in flight, so data never shows up unasked
  assert property (@(posedge clk) disable iff (rst) rd_valid |-> state == fetch_wait_data);

endmodule

`default_nettype wire

/* src/instr_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_mem #(
  parameter int depth = boot_pkg::mem_words,
  parameter int aw = boot_pkg::addr_w
) (
  input  logic          clk,
  input  logic          en,
  input  logic          we,
  input  logic [aw-1:0] addr,
  input  logic [31:0]   wdata,
  output logic [31:0]   rdata
);

  logic [31:0] mem [depth];

  // single port, read data one cycle after the address
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[addr] <= wdata;
      end else begin
        rdata <= mem[addr];
      end
    end
  end

endmodule

`default_nettype wire

/* src/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        wr_req,
  input  logic [boot_pkg::addr_w-1:0] wr_addr,
  input  logic [31:0]                 wr_data,
  input  logic                        rd_req,
  input  logic [boot_pkg::addr_w-1:0] rd_addr,
  output logic                        rd_gnt,
  output logic                        rd_valid,
  output logic [31:0]                 rd_data,
  output logic                        mem_en,
  output logic                        mem_we,
  output logic [boot_pkg::addr_w-1:0] mem_addr,
  output logic [31:0]                 mem_wdata,
  input  logic [31:0]                 mem_rdata
);

  // loader writes always win the port
  assign rd_gnt = rd_req && !wr_req;

  assign mem_en = wr_req || rd_req;
  assign mem_we = wr_req;
  assign mem_addr = wr_req ? wr_addr : rd_addr;
  assign mem_wdata = wr_data;

  // memory output is registered, so data lines up with rd_valid
  assign rd_data = mem_rdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_gnt;
    end
  end

  // a granted read has the port to itself, no write shares the cycle
  assert property (@(posedge clk) disable iff (rst)
    rd_gnt |-> mem_en && !mem_we && mem_addr == rd_addr);

endmodule

`default_nettype wire

/* src/program_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module program_loader (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [7:0]                  rx_byte,
  input  logic                        rx_byte_valid,
  output logic                        wr_req,
  output logic [boot_pkg::addr_w-1:0] wr_addr,
  output logic [31:0]                 wr_data,
  output logic                        start
);

  import boot_pkg::*;

  load_state_t state;
  logic [31:0] word_buf;
  logic [addr_w-1:0] word_addr;
  logic [addr_w-1:0] pad_base;
  logic [addr_w-1:0] pad_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= load_idle;
      word_addr <= '0;
      pad_cnt <= '0;
      start <= 1'b0;
    end else begin
      case (state)
        // most significant byte arrives first
        load_idle: begin
          if (rx_byte_valid) begin
            word_buf[31:24] <= rx_byte;
            state <= load_byte_1;
          end
        end

        load_byte_1: begin
          if (rx_byte_valid) begin
            word_buf[23:16] <= rx_byte;
            state <= load_byte_2;
          end
        end

        load_byte_2: begin
          if (rx_byte_valid) begin
            word_buf[15:8] <= rx_byte;
            state <= load_byte_3;
          end
        end

        load_byte_3: begin
          if (rx_byte_valid) begin
            word_buf[7:0] <= rx_byte;
            state <= load_done;
          end
        end

        // word goes to memory this cycle
        load_done: begin
          word_addr <= word_addr + 1'b1;
          // start is still low only before the first marker
          if (word_buf == halt_instr && !start) begin
            pad_base <= word_addr;
            pad_cnt <= '0;
            state <= load_pad;
          end else begin
            state <= load_idle;
          end
        end

        load_pad: begin
          pad_cnt <= pad_cnt + 1'b1;
          if (pad_cnt == addr_w'(pad_nops - 1)) begin
            state <= load_finished;
            start <= 1'b1;
          end
        end

        // halt write, then back to collecting bytes
        load_finished: begin
          state <= load_idle;
        end

        default: begin
          state <= load_idle;
        end
      endcase
    end
  end

  always_comb begin
    wr_req = 1'b0;
    wr_addr = word_addr;
    wr_data = word_buf;
    case (state)
      load_done: begin
        wr_req = 1'b1;
      end
      load_pad: begin
        wr_req = 1'b1;
        wr_addr = pad_base + pad_cnt;
        wr_data = nop_instr;
      end
      load_finished: begin
        wr_req = 1'b1;
        wr_addr = pad_base + addr_w'(pad_nops);
        wr_data = halt_instr;
      end
      default: begin
        wr_req = 1'b0;
      end
    endcase
  end

  // back to back writes only inside the padding tail
  assert property (@(posedge clk) disable iff (rst)
    wr_req && !(state inside {load_pad, load_finished}) |=> !wr_req || state == load_pad);

  // start holds until the next reset
  assert property (@(posedge clk) !rst && !$past(rst) && $past(start) |-> start);

endmodule

`default_nettype wire

/* src/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic       clk,
  input  logic       rst,
  input  logic       rx_serial,
  output logic [7:0] rx_byte,
  output logic       rx_byte_valid
);

  import boot_pkg::*;

  rx_state_t state;
  logic rx_meta;
  logic rx_sync;
  logic [bit_cnt_w-1:0] bit_cnt;
  logic [2:0] bit_idx;
  logic [7:0] shift;

  // two flops in front of the fsm, line idles high
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_serial;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rx_idle;
      bit_cnt <= '0;
      bit_idx <= '0;
      rx_byte_valid <= 1'b0;
    end else begin
      rx_byte_valid <= 1'b0;
      case (state)
        rx_idle: begin
          bit_cnt <= '0;
          if (!rx_sync) begin
            state <= rx_start_bit;
          end
        end

        rx_start_bit: begin
          // check the line again half a bit in
          if (bit_cnt == bit_cnt_w'(clks_per_bit / 2 - 1)) begin
            bit_cnt <= '0;
            bit_idx <= '0;
            if (rx_sync) begin
              state <= rx_idle;
            end else begin
              state <= rx_data_bits;
            end
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end

        rx_data_bits: begin
          if (bit_cnt == bit_cnt_w'(clks_per_bit - 1)) begin
            bit_cnt <= '0;
            // lsb first on the wire
            shift <= {rx_sync, shift[7:1]};
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= rx_stop_bit;
            end
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end

        rx_stop_bit: begin
          if (bit_cnt == bit_cnt_w'(clks_per_bit - 1)) begin
            bit_cnt <= '0;
            state <= rx_idle;
            // bad stop bit drops the frame
            if (rx_sync) begin
              rx_byte <= shift;
              rx_byte_valid <= 1'b1;
            end
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end

        default: begin
          state <= rx_idle;
        end
      endcase
    end
  end

  // one strobe per frame, never a held level
  assert property (@(posedge clk) disable iff (rst) rx_byte_valid |=> !rx_byte_valid);

endmodule

`default_nettype wire

/* tb/boot_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module boot_top_tb;

  import boot_pkg::*;

  localparam logic [31:0] rand_seed = 32'hca7a9982;
  localparam int reset_cycles = 3;
  localparam int idle_check_cycles = 200;
  localparam int quiet_cycles = 100;
  localparam int settle_cycles = 20;
  localparam int max_rand_words = 12;
  // strobe cycle, word write, nop writes, then halt write with start
  localparam int start_delay = 1 + 1 + pad_nops + 1;
  // words per test: glitch, fixed, byte order, random, reboot
  localparam int bytes_sent = 4 * (3 + 5 + 5 + (max_rand_words + 1) + 3);
  localparam int fetch_cycles = 4 * 3 * (max_rand_words + pad_nops + 1);
  localparam int idle_cycles = idle_check_cycles + quiet_cycles + 11 * clks_per_bit
                               + 4 * settle_cycles + 6 * (reset_cycles + 1);
  localparam int watchdog_cycles =
    (bytes_sent * 10 * clks_per_bit + fetch_cycles + idle_cycles) * 3 / 2;

  logic clk;
  logic rst;
  logic rx_serial;
  logic [31:0] instr;
  logic [addr_w-1:0] instr_addr;
  logic instr_valid;
  logic start;
  logic halted;

  int error_count = 0;
  int test_errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int unsigned seed_state;
  logic [31:0] program_q [$];

  // fetch stream and event times seen by the monitor
  int cycle = 0;
  int strobe_cycle;
  int start_cycle;
  int start_strobe_cycle;
  int halt_cycle;
  int last_valid_cycle;
  int extra_valids;
  logic start_seen;
  logic halt_seen;
  logic [31:0] got_instr [$];
  logic [addr_w-1:0] got_addr [$];

  tb_clock #(.period(100)) u_clock (
    .clk(clk)
  );

  boot_top uut (
    .clk        (clk),
    .rst        (rst),
    .rx_serial  (rx_serial),
    .instr      (instr),
    .instr_addr (instr_addr),
    .instr_valid(instr_valid),
    .start      (start),
    .halted     (halted)
  );

  // outputs settle after the rising edge, so sample them on the falling one
  always @(negedge clk) begin
    cycle = cycle + 1;
    if (uut.rx_byte_valid) begin
      strobe_cycle = cycle;
    end
    if (start && !start_seen) begin
      start_seen = 1'b1;
      start_cycle = cycle;
      start_strobe_cycle = strobe_cycle;
    end
    if (halted && !halt_seen) begin
      halt_seen = 1'b1;
      halt_cycle = cycle;
    end
    if (instr_valid) begin
      if (halt_seen) begin
        extra_valids = extra_valids + 1;
      end else begin
        got_instr.push_back(instr);
        got_addr.push_back(instr_addr);
        last_valid_cycle = cycle;
      end
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
    $display("Test failures found");
    $finish;
  end

  task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("mismatch at %0d ns: %s expected 0x%h got 0x%h", $time, sig, expected, actual);
    error_count = error_count + 1;
    test_errors = test_errors + 1;
  endtask

  task automatic report_failure(input string msg);
    $display("error at %0d ns: %s", $time, msg);
    error_count = error_count + 1;
    test_errors = test_errors + 1;
  endtask

  task automatic finish_test(input string name);
    tests_run = tests_run + 1;
    if (test_errors != 0) begin
      tests_failed = tests_failed + 1;
      $display("test %s: FAIL with %0d errors", name, test_errors);
    end else begin
      $display("test %s: PASS", name);
    end
    test_errors = 0;
  endtask

  task automatic clear_monitor();
    strobe_cycle = -1;
    start_cycle = -1;
    start_strobe_cycle = -1;
    halt_cycle = -1;
    last_valid_cycle = -1;
    extra_valids = 0;
    start_seen = 1'b0;
    halt_seen = 1'b0;
    got_instr.delete();
    got_addr.delete();
  endtask

  // leaves the caller on a falling edge with rst low
  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    rx_serial = 1'b1;
    repeat (reset_cycles) @(negedge clk);
    rst = 1'b0;
    clear_monitor();
  endtask

  // 8N1, lsb first
  task automatic send_byte(input logic [7:0] value);
    int i;
    rx_serial = 1'b0;
    repeat (clks_per_bit) @(negedge clk);
    for (i = 0; i < 8; i++) begin
      rx_serial = value[i];
      repeat (clks_per_bit) @(negedge clk);
    end
    rx_serial = 1'b1;
    repeat (clks_per_bit) @(negedge clk);
  endtask

  task automatic send_word(input logic [31:0] word);
    send_byte(word[31:24]);
    send_byte(word[23:16]);
    send_byte(word[15:8]);
    send_byte(word[7:0]);
  endtask

  task automatic wait_for_halted(input int limit);
    int n;
    n = 0;
    while (!halted && n < limit) begin
      @(negedge clk);
      n = n + 1;
    end
    if (!halted) begin
      report_failure("halted did not rise after the boot");
    end
  endtask

  // model: program words, pad_nops nops from the marker address, then halt
  task automatic check_fetch_stream();
    logic [31:0] exp_instr [$];
    logic [addr_w-1:0] exp_addr [$];
    int m;
    int i;
    int delay;
    m = program_q.size();
    for (i = 0; i < m; i++) begin
      exp_instr.push_back(program_q[i]);
      exp_addr.push_back(addr_w'(i));
    end
    for (i = 0; i < pad_nops; i++) begin
      exp_instr.push_back(nop_instr);
      exp_addr.push_back(addr_w'(m + i));
    end
    exp_instr.push_back(halt_instr);
    exp_addr.push_back(addr_w'(m + pad_nops));

    if (!start_seen) begin
      report_failure("start never rose after the marker");
    end else begin
      delay = start_cycle - start_strobe_cycle + 1;
      if (delay != start_delay) begin
        report_mismatch("start delay in cycles", start_delay, delay);
      end
    end
    if (got_instr.size() != exp_instr.size()) begin
      report_mismatch("fetched word count", exp_instr.size(), got_instr.size());
    end
    for (i = 0; i < exp_instr.size() && i < got_instr.size(); i++) begin
      if (got_instr[i] != exp_instr[i]) begin
        report_mismatch($sformatf("instr[%0d]", i), exp_instr[i], got_instr[i]);
      end
      if (got_addr[i] != exp_addr[i]) begin
        report_mismatch($sformatf("instr_addr[%0d]", i), exp_addr[i], got_addr[i]);
      end
    end
    if (halt_seen && halt_cycle != last_valid_cycle + 1) begin
      report_failure("halted did not follow the halt word by one cycle");
    end
    if (extra_valids != 0) begin
      report_mismatch("instr_valid after halted", 0, extra_valids);
    end
  endtask

  task automatic run_boot();
    int i;
    for (i = 0; i < program_q.size(); i++) begin
      send_word(program_q[i]);
    end
    send_word(halt_instr);
    wait_for_halted(4 * (program_q.size() + pad_nops + 1) + settle_cycles);
    repeat (settle_cycles) @(negedge clk);
    check_fetch_stream();
  endtask

  task automatic check_idle_after_reset();
    int i;
    apply_reset();
    for (i = 0; i <= idle_check_cycles; i++) begin
      if (start !== 1'b0) begin
        report_mismatch("start", 0, start);
      end
      if (halted !== 1'b0) begin
        report_mismatch("halted", 0, halted);
      end
      if (instr_valid !== 1'b0) begin
        report_mismatch("instr_valid", 0, instr_valid);
      end
      @(negedge clk);
    end
    finish_test("idle after reset");
  endtask

  task automatic reject_glitch_without_marker();
    apply_reset();
    // low for less than half a bit
    rx_serial = 1'b0;
    repeat (clks_per_bit / 2 - 1) @(negedge clk);
    rx_serial = 1'b1;
    // long enough for a false frame to end as a 0xff byte
    repeat (10 * clks_per_bit) @(negedge clk);
    // a false 0xff byte ahead of this word would complete a marker
    send_word(32'hffff_ff13);
    send_word(32'h0062_8333);
    send_word(32'h0000_8067);
    repeat (quiet_cycles) @(negedge clk);
    if (start_seen || start) begin
      report_failure("start rose although no marker was sent");
    end
    if (got_instr.size() != 0) begin
      report_mismatch("instr_valid count", 0, got_instr.size());
    end
    finish_test("glitch and no marker");
  endtask

  task automatic boot_fixed_program();
    apply_reset();
    program_q = '{32'h0010_0093, 32'h0020_0113, 32'h0020_81b3, 32'h0000_006f};
    run_boot();
    finish_test("fixed program boot");
  endtask

  task automatic verify_byte_order();
    apply_reset();
    program_q = '{32'h1122_3344, 32'ha5b6_c7d8, 32'h0102_0304, 32'hf0e0_d0c0};
    run_boot();
    finish_test("byte order");
  endtask

  task automatic boot_random_program();
    int count;
    int i;
    logic [31:0] word;
    apply_reset();
    program_q.delete();
    count = $urandom_range(max_rand_words, 1);
    for (i = 0; i < count; i++) begin
      word = $urandom();
      // an all ones word would end the load early
      if (word == halt_instr) begin
        word = 32'h7fff_ffff;
      end
      program_q.push_back(word);
    end
    run_boot();
    finish_test($sformatf("random program of %0d words", count));
  endtask

  task automatic reboot_after_reset();
    apply_reset();
    if (start !== 1'b0) begin
      report_mismatch("start after reset", 0, start);
    end
    if (halted !== 1'b0) begin
      report_mismatch("halted after reset", 0, halted);
    end
    program_q = '{32'h00a0_0513, 32'h0000_0073};
    run_boot();
    finish_test("reboot after reset");
  endtask

  initial begin
    rst = 1'b1;
    rx_serial = 1'b1;
    seed_state = $urandom(rand_seed);
    check_idle_after_reset();
    reject_glitch_without_marker();
    boot_fixed_program();
    verify_byte_order();
    boot_random_program();
    reboot_after_reset();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int period = 100
) (
  output logic clk
);

  // free running, low at time zero
  initial begin
    clk = 1'b0;
    forever begin
      #(period / 2) clk = ~clk;
    end
  end

endmodule

`default_nettype wire
